// File: logic/noc_consts.svh
// Router slice constants: port count, queue depth and flit field widths
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// --------------------------------------------------
// Topology
// --------------------------------------------------

// Inputs and outputs of the slice, one per mesh direction in use
`define NOC_PORTS 3

// Entries per virtual-output FIFO
`define NOC_VC_DEPTH 4

// --------------------------------------------------
// Flit fields
// --------------------------------------------------

`define NOC_PAYLOAD_W 16 // Data bits carried per flit

// Port index width, must hold NOC_PORTS-1
`define NOC_PORT_W 2

`endif

// File: logic/noc_port_pkg.sv
// Port package: port numbers, one-hot port vectors and port-by-port matrices
`include "noc_consts.svh"

package noc_port_pkg;

  // --------------------------------------------------
  // Port addressing
  // --------------------------------------------------

  typedef logic [`NOC_PORT_W-1:0] port_idx_t; // One port number

  // One bit per port, bit 0 is port 0
  typedef logic [`NOC_PORTS-1:0] port_vec_t;

  // Request and grant matrices, outer index is the input
  typedef port_vec_t [`NOC_PORTS-1:0] port_mat_t;

endpackage

// File: logic/noc_flit_pkg.sv
// Flit package: the flit word held in every queue and its per-port arrays
`include "noc_consts.svh"

package noc_flit_pkg;

  import noc_port_pkg::*;

  // --------------------------------------------------
  // Flit word
  // --------------------------------------------------

  // Single-flit packet, no head/tail framing
  typedef struct packed {
    port_idx_t                  src;     // Input port it entered on
    port_idx_t                  dest;    // Output port it must leave on
    logic [`NOC_PAYLOAD_W-1:0]  payload; // User data
  } flit_t;

  // --------------------------------------------------
  // Flit arrays
  // --------------------------------------------------

  // One flit per port, as on the router's data ports
  typedef flit_t [`NOC_PORTS-1:0] flit_vec_t;

  // Heads of all queues, outer index input, inner index output
  typedef flit_vec_t [`NOC_PORTS-1:0] flit_mat_t;

endpackage

// File: logic/noc_fifo.sv
// Circular-buffer FIFO with valid/enable handshake on both sides and any payload type
`timescale 1ns/1ns

module noc_fifo #(
  parameter type T     = logic [7:0], // Payload stored per entry
  parameter int  DEPTH = 4            // Number of entries
) (
  input  logic clk,
  input  logic i_rst_n,
  input  logic i_ce,        // Clock enable, all state holds while low

  // Write side
  input  T     i_data,      // Payload from upstream
  input  logic i_data_val,  // Write request
  output logic o_en,        // Space available (not full)

  // Read side
  output T     o_data,      // Head entry, valid with o_data_val
  output logic o_data_val,  // Not empty
  input  logic i_en         // Pop the head on this edge
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // Pointer width
  localparam int CW = $clog2(DEPTH + 1);               // Count width, 0..DEPTH

  // --------------------------------------------------
  // Storage and state
  // --------------------------------------------------
  T              r_mem [DEPTH];
  logic [AW-1:0] r_wr_ptr;
  logic [AW-1:0] r_rd_ptr;
  logic [CW-1:0] r_count;   // Occupancy
  logic          l_wr;
  logic          l_rd;

  // Pointer step with wrap at the last entry
  function automatic logic [AW-1:0] f_next(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign o_en       = (r_count != CW'(DEPTH));
  assign o_data_val = (r_count != '0);
  assign o_data     = r_mem[r_rd_ptr]; // Head is read straight from the array

  assign l_wr = i_ce & i_data_val & o_en;       // Accepted write
  assign l_rd = i_ce & i_en & o_data_val;       // Accepted pop

  always_ff @(posedge clk) begin
    if (l_wr) begin
      r_mem[r_wr_ptr] <= i_data;
    end
  end

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (l_wr) r_wr_ptr <= f_next(r_wr_ptr);
      if (l_rd) r_rd_ptr <= f_next(r_rd_ptr);
      case ({l_wr, l_rd})
        2'b10:   r_count <= r_count + 1'b1; // Write only
        2'b01:   r_count <= r_count - 1'b1; // Pop only
        default: r_count <= r_count;        // Both or neither
      endcase
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Writer must follow o_en, a write request while full is a steering fault
  a_no_write_full : assert property (
    @(posedge clk) disable iff (!i_rst_n) i_data_val |-> o_en
  ) else $error("noc_fifo: write while full");

  // Allocator only pops queues that reported a request
  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (!i_rst_n) i_en |-> o_data_val
  ) else $error("noc_fifo: pop while empty");

endmodule

// File: logic/noc_voq.sv
// Virtual output queue: one FIFO per output, one-hot write steering and one-hot pop
`timescale 1ns/1ns
`include "noc_consts.svh"

module noc_voq
  import noc_port_pkg::*, noc_flit_pkg::*;
#(
  parameter int DEPTH = `NOC_VC_DEPTH // Entries per output queue
) (
  input  logic      clk,
  input  logic      i_rst_n,
  input  logic      i_ce,

  // Upstream
  input  flit_t     i_flit,   // Shared by all queues
  input  port_vec_t i_val,    // One-hot destination, zero when idle
  output logic      o_en,     // Selected queue has room

  // Towards the allocator
  output flit_vec_t o_head,   // Head flit of each queue
  output port_vec_t o_req,    // Queue non-empty
  input  port_vec_t i_pop     // One-hot pop from the allocator
);

  // --------------------------------------------------
  // Local signals
  // --------------------------------------------------
  port_vec_t l_en;      // Per-queue not full
  port_vec_t l_wr_val;  // Write request steered to one queue

  // Only the addressed queue counts, idle input leaves o_en high
  assign o_en = &(l_en | ~i_val);

  // Never request into a full queue
  assign l_wr_val = i_val & {`NOC_PORTS{o_en}};

  // --------------------------------------------------
  // Queues, one per output
  // --------------------------------------------------
  for (genvar gq = 0; gq < `NOC_PORTS; gq++) begin : g_vc
    noc_fifo #(
      .T     (flit_t),
      .DEPTH (DEPTH)
    ) u_fifo (
      .clk,
      .i_rst_n,
      .i_ce,
      .i_data     (i_flit),        // Same flit offered to every queue
      .i_data_val (l_wr_val[gq]),
      .o_en       (l_en[gq]),
      .o_data     (o_head[gq]),
      .o_data_val (o_req[gq]),     // Request straight to the allocator
      .i_en       (i_pop[gq])
    );
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Upstream route logic gives exactly one destination
  a_val_onehot : assert property (
    @(posedge clk) disable iff (!i_rst_n) $onehot0(i_val)
  ) else $error("noc_voq: i_val not one-hot");

  // At most one flit leaves this input per cycle
  a_pop_onehot : assert property (
    @(posedge clk) disable iff (!i_rst_n) $onehot0(i_pop)
  ) else $error("noc_voq: i_pop not one-hot");

endmodule

// File: logic/noc_rr_arbiter.sv
// Round-robin arbiter, combinational one-hot grant with a rotating priority pointer
`timescale 1ns/1ns

module noc_rr_arbiter #(
  parameter int N = 3 // Number of requesters
) (
  input  logic         clk,
  input  logic         i_rst_n,
  input  logic         i_ce,
  input  logic [N-1:0] i_req,    // Request per requester
  input  logic         i_accept, // Grant taken, rotate past the winner
  output logic [N-1:0] o_grant   // One-hot, zero when no request
);

  localparam int PW = (N > 1) ? $clog2(N) : 1;

  logic [PW-1:0] r_ptr;  // Highest priority requester
  logic [PW-1:0] l_win;  // Index of the current winner

  // --------------------------------------------------
  // Grant search from the pointer
  // --------------------------------------------------
  always_comb begin
    int   idx;
    logic found;
    o_grant = '0;
    l_win   = r_ptr;
    found   = 1'b0;
    for (int i = 0; i < N; i++) begin
      idx = (int'(r_ptr) + i) % N;        // Wraps around past N-1
      if (!found && i_req[idx]) begin
        o_grant[idx] = 1'b1;
        l_win        = PW'(idx);
        found        = 1'b1;
      end
    end
  end

  // Pointer moves only on an accepted grant, so a refused winner keeps priority
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_ptr <= '0;
    end else if (i_ce && i_accept && |i_req) begin
      r_ptr <= (l_win == PW'(N - 1)) ? '0 : l_win + 1'b1;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_grant_ok : assert property (
    @(posedge clk) disable iff (!i_rst_n)
    |i_req |-> ($onehot(o_grant) && ((o_grant & ~i_req) == '0))
  ) else $error("noc_rr_arbiter: bad grant");

endmodule

// File: logic/noc_switch_alloc.sv
// Separable input-first switch allocator with the crossbar output multiplexers
`timescale 1ns/1ns
`include "noc_consts.svh"

module noc_switch_alloc
  import noc_port_pkg::*, noc_flit_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst_n,
  input  logic      i_ce,
  input  port_mat_t i_req,       // [input][output] queue non-empty
  input  flit_mat_t i_head,      // [input][output] head flits
  input  port_vec_t i_out_rdy,   // Downstream can take a flit
  output port_mat_t o_pop,       // [input][output] one-hot pop per input
  output flit_vec_t o_out_flit,  // Crossbar output data
  output port_vec_t o_out_val    // Single-cycle transfer strobe
);

  // --------------------------------------------------
  // Local signals
  // --------------------------------------------------
  port_mat_t l_in_req;   // [input][output] ready-masked requests
  port_mat_t l_in_gnt;   // [input][output] input-stage choice
  port_mat_t l_out_req;  // [output][input] transposed choices
  port_mat_t l_out_gnt;  // [output][input] final winners
  port_vec_t l_in_acc;   // Input-stage choice won at the output

  // Blocked outputs and a stalled clock never enter arbitration
  always_comb begin
    for (int i = 0; i < `NOC_PORTS; i++) begin
      l_in_req[i] = i_req[i] & i_out_rdy & {`NOC_PORTS{i_ce}};
    end
  end

  // Turn input choices into per-output requests, winners back into pops
  always_comb begin
    for (int i = 0; i < `NOC_PORTS; i++) begin
      for (int q = 0; q < `NOC_PORTS; q++) begin
        l_out_req[q][i] = l_in_gnt[i][q];
        o_pop[i][q]     = l_out_gnt[q][i];
      end
    end
    for (int i = 0; i < `NOC_PORTS; i++) begin
      l_in_acc[i] = |o_pop[i];   // Input stage rotates only when it won
    end
  end

  // --------------------------------------------------
  // Arbiters
  // --------------------------------------------------
  for (genvar gi = 0; gi < `NOC_PORTS; gi++) begin : g_in_arb
    noc_rr_arbiter #(.N(`NOC_PORTS)) u_arb (
      .clk, .i_rst_n, .i_ce,
      .i_req    (l_in_req[gi]),  // Pick one output per input
      .i_accept (l_in_acc[gi]),
      .o_grant  (l_in_gnt[gi])
    );

    a_one_pop : assert property (
      @(posedge clk) disable iff (!i_rst_n) $onehot0(o_pop[gi])
    ) else $error("noc_switch_alloc: input %0d pops twice", gi);
  end

  for (genvar gq = 0; gq < `NOC_PORTS; gq++) begin : g_out_arb
    noc_rr_arbiter #(.N(`NOC_PORTS)) u_arb (
      .clk, .i_rst_n, .i_ce,
      .i_req    (l_out_req[gq]), // Pick one input per output
      .i_accept (|l_out_gnt[gq]), // Final stage, a grant is always taken
      .o_grant  (l_out_gnt[gq])
    );
  end

  // --------------------------------------------------
  // Crossbar
  // --------------------------------------------------
  always_comb begin
    for (int q = 0; q < `NOC_PORTS; q++) begin
      o_out_val[q]  = |l_out_gnt[q];
      o_out_flit[q] = '0;
      for (int i = 0; i < `NOC_PORTS; i++) begin
        if (l_out_gnt[q][i]) o_out_flit[q] = i_head[i][q];
      end
    end
  end

endmodule

// File: logic/noc_router.sv
// Input-queued router slice: per-input virtual output queues feeding a switch allocator
`timescale 1ns/1ns
`include "noc_consts.svh"

module noc_router
  import noc_port_pkg::*, noc_flit_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst_n,
  input  logic      i_ce,        // Clock enable for the whole slice

  // Upstream, one lane per input
  input  flit_vec_t i_in_flit,
  input  port_mat_t i_in_val,    // One-hot destination per input
  output port_vec_t o_in_en,     // Addressed queue has room

  // Downstream, one lane per output
  output flit_vec_t o_out_flit,
  output port_vec_t o_out_val,   // Transfer strobe
  input  port_vec_t i_out_rdy
);

  // --------------------------------------------------
  // Queue to allocator wiring
  // --------------------------------------------------
  port_mat_t l_req;   // [input][output] non-empty
  flit_mat_t l_head;  // [input][output] head flits
  port_mat_t l_pop;   // [input][output] pops

  for (genvar gi = 0; gi < `NOC_PORTS; gi++) begin : g_in
    noc_voq #(.DEPTH(`NOC_VC_DEPTH)) u_voq (
      .clk,
      .i_rst_n,
      .i_ce,
      .i_flit (i_in_flit[gi]),
      .i_val  (i_in_val[gi]),
      .o_en   (o_in_en[gi]),
      .o_head (l_head[gi]),
      .o_req  (l_req[gi]),
      .i_pop  (l_pop[gi])
    );
  end

  // Allocation and crossbar
  noc_switch_alloc u_alloc (
    .clk,
    .i_rst_n,
    .i_ce,
    .i_req      (l_req),
    .i_head     (l_head),
    .i_out_rdy  (i_out_rdy),
    .o_pop      (l_pop),
    .o_out_flit (o_out_flit),
    .o_out_val  (o_out_val)
  );

endmodule

// File: tests/tb_noc_checks.svh
// Router testbench model: per source/destination flit queues and typed compare tasks
`ifndef TB_NOC_CHECKS_SVH
`define TB_NOC_CHECKS_SVH

// --------------------------------------------------
// Reference model
// --------------------------------------------------
flit_t model_q   [`NOC_PORTS][`NOC_PORTS][$]; // [src][dest] flits in arrival order
int    model_occ [`NOC_PORTS][`NOC_PORTS];    // [src][dest] occupancy, mirrors one FIFO
int    n_val_err   = 0;                       // Wrong values
int    n_other_err = 0;                       // Missing or unexpected flits

task automatic check_flit(input string name, input flit_t got, input flit_t exp);
  if (got !== exp) begin
    n_val_err++;
    $display("ERROR %s got %h expected %h at %0t ns", name, got, exp, $time);
  end
endtask

task automatic check_vec(input string name, input port_vec_t got, input port_vec_t exp);
  if (got !== exp) begin
    n_val_err++;
    $display("ERROR %s got %h expected %h at %0t ns", name, got, exp, $time);
  end
endtask

task automatic report_fault(input string msg);
  n_other_err++;
  $display("Failure at %0t ns: %s", $time, msg);
endtask

// Accepted upstream write
task automatic model_push(input flit_t f);
  model_q[f.src][f.dest].push_back(f);
  model_occ[f.src][f.dest]++;
endtask

// Strobed flit on output q must be the oldest flit of its pair
task automatic model_pop_check(input int q, input flit_t got);
  if (int'(got.src) >= `NOC_PORTS) begin
    report_fault($sformatf("output %0d delivered a flit with invalid source %0d", q, got.src));
  end else if (model_q[got.src][q].size() == 0) begin
    report_fault($sformatf("output %0d delivered a flit that was never sent", q));
  end else begin
    check_flit($sformatf("o_out_flit[%0d]", q), got, model_q[got.src][q][0]);
    void'(model_q[got.src][q].pop_front());
    model_occ[got.src][q]--;
  end
endtask

// Flits accepted by the router but not yet delivered
function automatic int pending_flits();
  int sum;
  sum = 0;
  for (int s = 0; s < `NOC_PORTS; s++) begin
    for (int d = 0; d < `NOC_PORTS; d++) sum += model_occ[s][d];
  end
  return sum;
endfunction

`endif

// File: tests/tb_noc_router.sv
// Router slice testbench: random traffic in phases, model checks, drain and summary
`timescale 1ns/1ns
`include "noc_consts.svh"

module tb_noc_router
  import noc_port_pkg::*, noc_flit_pkg::*;
;

  localparam int SEED           = 94771;
  localparam int PHASE_CYCLES   = 500;
  localparam int NUM_PHASES     = 4;
  localparam int STIM_CYCLES    = PHASE_CYCLES * NUM_PHASES;
  localparam int DRAIN_MARGIN   = `NOC_PORTS * `NOC_PORTS * `NOC_VC_DEPTH * 8 + 200;
  localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + DRAIN_MARGIN;

  logic      clk;
  logic      i_rst_n;
  logic      i_ce;
  flit_vec_t i_in_flit;
  port_mat_t i_in_val;
  port_vec_t o_in_en;
  flit_vec_t o_out_flit;
  port_vec_t o_out_val;
  port_vec_t i_out_rdy;

  flit_vec_t cur_flit;      // Flit each upstream is offering
  port_vec_t busy = '0;     // Upstream holds a flit until accepted
  int        n_sent = 0;
  int        n_recv = 0;
  int        cycle_cnt = 0;

  `include "tb_noc_checks.svh"

  noc_router UUT (
    .clk, .i_rst_n, .i_ce,
    .i_in_flit, .i_in_val, .o_in_en,
    .o_out_flit, .o_out_val, .i_out_rdy
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;    // 40 ns period

  function automatic port_vec_t dest_onehot(input port_idx_t d);
    return port_vec_t'(1) << d;
  endfunction

  // Fresh random flit on input p, held until the router takes it
  task automatic new_offer(input int p);
    logic [31:0] rnd;
    rnd                 = $urandom;
    cur_flit[p].src     = port_idx_t'(p);                          // Source is own port
    cur_flit[p].dest    = port_idx_t'($urandom % `NOC_PORTS);
    cur_flit[p].payload = rnd[`NOC_PAYLOAD_W-1:0];
    busy[p]             = 1'b1;
  endtask

  // --------------------------------------------------
  // Stimulus for one cycle, traffic mix set by phase
  // --------------------------------------------------
  task automatic drive_cycle(input int ph);
    int prob;
    prob      = (ph == 3) ? 90 : 60;                               // Last phase floods
    i_ce      = (ph == 2) ? (($urandom % 100) < 70) : 1'b1;        // Stalls only in phase 2
    for (int q = 0; q < `NOC_PORTS; q++) begin
      case (ph)
        0:       i_out_rdy[q] = 1'b1;
        3:       i_out_rdy[q] = ($urandom % 100) < 20;             // Heavy back-pressure
        default: i_out_rdy[q] = ($urandom % 100) < 50;
      endcase
    end
    for (int p = 0; p < `NOC_PORTS; p++) begin
      if (!busy[p] && (($urandom % 100) < prob)) begin
        new_offer(p);
      end
      i_in_flit[p] = cur_flit[p];
      i_in_val[p]  = busy[p] ? dest_onehot(cur_flit[p].dest) : '0;
    end
  endtask

  // --------------------------------------------------
  // Monitor, samples mid-cycle when inputs and outputs are settled
  // --------------------------------------------------
  always @(negedge clk) begin : monitor
    port_vec_t exp_en;
    if (i_rst_n) begin
      for (int p = 0; p < `NOC_PORTS; p++) begin
        exp_en[p] = 1'b1;
        for (int q = 0; q < `NOC_PORTS; q++) begin
          if (i_in_val[p][q] && model_occ[p][q] == `NOC_VC_DEPTH) exp_en[p] = 1'b0;
        end
      end
      check_vec("o_in_en", o_in_en, exp_en);
      check_vec("o_out_val (blocked lanes)", o_out_val & ~(i_out_rdy & {`NOC_PORTS{i_ce}}), '0);
      for (int q = 0; q < `NOC_PORTS; q++) begin
        if (o_out_val[q]) begin
          model_pop_check(q, o_out_flit[q]);                       // Pop before push
          n_recv++;
        end
      end
      for (int p = 0; p < `NOC_PORTS; p++) begin
        if (i_ce && (i_in_val[p] != '0) && o_in_en[p]) begin
          model_push(i_in_flit[p]);
          busy[p] = 1'b0;
          n_sent++;
        end
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout at cycle %0d: %0d flits queued, %0d value errors, %0d other errors",
               cycle_cnt, pending_flits(), n_val_err, n_other_err);
      $display("Regression failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin : stimulus
    void'($urandom(SEED));
    i_rst_n   = 1'b0;
    i_ce      = 1'b0;
    i_in_flit = '0;
    i_in_val  = '0;
    i_out_rdy = '0;
    cur_flit  = '0;
    repeat (5) @(posedge clk);
    #2 i_rst_n = 1'b1;
    i_ce      = 1'b1;
    i_out_rdy = '1;                                                // Every lane free to strobe
    for (int p = 0; p < `NOC_PORTS; p++) begin
      new_offer(p);                                                // Live offers test the enables
      i_in_flit[p] = cur_flit[p];
      i_in_val[p]  = dest_onehot(cur_flit[p].dest);
    end
    @(negedge clk);
    check_vec("o_out_val", o_out_val, '0);                         // Empty after reset
    check_vec("o_in_en", o_in_en, '1);
    for (int ph = 0; ph < NUM_PHASES; ph++) begin
      for (int c = 0; c < PHASE_CYCLES; c++) begin
        @(posedge clk);
        #2 drive_cycle(ph);
      end
    end
    @(posedge clk);
    #2 i_in_val = '0;                                              // Stop traffic, drop offers
    busy      = '0;
    i_ce      = 1'b1;
    i_out_rdy = '1;
    while (pending_flits() != 0) @(posedge clk);
    repeat (2 * `NOC_VC_DEPTH) @(posedge clk);                     // Stray strobes show here
    if (n_sent != n_recv) report_fault($sformatf("%0d flits in but %0d out", n_sent, n_recv));
    $display("Summary: %0d value errors, %0d other errors, %0d flits in, %0d flits out",
             n_val_err, n_other_err, n_sent, n_recv);
    if (n_val_err + n_other_err == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+logic
+incdir+tests
logic/noc_port_pkg.sv
logic/noc_flit_pkg.sv
logic/noc_fifo.sv
logic/noc_voq.sv
logic/noc_rr_arbiter.sv
logic/noc_switch_alloc.sv
logic/noc_router.sv
tests/tb_noc_router.sv

// File: Bender.yml
package:
  name: noc_router

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/noc_port_pkg.sv
      - logic/noc_flit_pkg.sv
      - logic/noc_fifo.sv
      - logic/noc_voq.sv
      - logic/noc_rr_arbiter.sv
      - logic/noc_switch_alloc.sv
      - logic/noc_router.sv
  - target: test
    include_dirs:
      - logic
      - tests
    files:
      - tests/tb_noc_router.sv
